// File: logic/ppuPkg.sv
`default_nettype none

package ppuPkg;

    // raster
    localparam int H_TOTAL      = 100;
    localparam int H_ACTIVE     = 80;
    localparam int H_SYNC_START = H_ACTIVE + 4;
    localparam int H_SYNC_END   = H_SYNC_START + 7;   // inclusive
    localparam int V_TOTAL      = 64;
    localparam int V_ACTIVE     = 60;
    localparam int V_SYNC_START = V_ACTIVE + 1;
    localparam int V_SYNC_END   = V_SYNC_START + 1;   // inclusive
    localparam int POS_BITS     = 7;

    // tiles and the game window
    localparam int TILE_SIZE    = 8;
    localparam int TILE_SHIFT   = $clog2(TILE_SIZE);
    localparam int TILE_COLS    = 8;
    localparam int TILE_ROWS    = 6;
    localparam int WIN_W        = TILE_COLS * TILE_SIZE;
    localparam int WIN_H        = TILE_ROWS * TILE_SIZE;
    localparam int WIN_X0       = (H_ACTIVE - WIN_W) / 2;   // centred in active area
    localparam int WIN_Y0       = (V_ACTIVE - WIN_H) / 2;

    localparam int NUM_SPRITES  = 8;
    localparam int NUM_TILES    = TILE_COLS * TILE_ROWS;

    // apb
    localparam int APB_ADDR_BITS = 8;
    localparam int APB_DATA_BITS = 32;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgbT;

    localparam rgbT TRANSPARENT_KEY0 = 12'h000;
    localparam rgbT TRANSPARENT_KEY1 = 12'h209;

    typedef struct packed {
        logic       enable;
        logic [5:0] y;      // window coords, top edge
        logic [5:0] x;      // left edge
        rgbT        color;
    } spriteEntryT;

    typedef struct packed {
        rgbT color;
    } tileEntryT;

endpackage

`default_nettype wire

// File: logic/apbIf.sv
`timescale 1ns/1ps
`default_nettype none

interface apbIf import ppuPkg::*; ();

    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [APB_ADDR_BITS-1:0] paddr;
    logic [APB_DATA_BITS-1:0] pwdata;
    logic [APB_DATA_BITS-1:0] prdata;
    logic                     pready;
    logic                     pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

// File: logic/apbTableRam.sv
`timescale 1ns/1ps
`default_nettype none

module apbTableRam import ppuPkg::*; #(
    parameter type entryT = tileEntryT,
    parameter int  DEPTH  = NUM_TILES
) (
    input  wire logic clk_50MHz,
    input  wire logic rstn,
    apbIf.slave       bus,
    output entryT     entries [DEPTH]
);

    localparam int ENTRY_BITS = $bits(entryT);

    logic [APB_ADDR_BITS-3:0] idx;
    logic                     inRange;
    logic                     access;
    logic [APB_DATA_BITS-1:0] rdWord;

    assign idx     = bus.paddr[APB_ADDR_BITS-1:2];   // word index
    assign inRange = int'(idx) < DEPTH;
    assign access  = bus.psel && bus.penable;

    // no wait states
    assign bus.pready  = access;
    assign bus.pslverr = access && !inRange;

    always_comb begin
        rdWord = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (int'(idx) == i) begin
                rdWord[ENTRY_BITS-1:0] = entries[i];
            end
        end
    end

    assign bus.prdata = (bus.psel && !bus.pwrite && inRange) ? rdWord : '0;

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i] <= '0;
            end
        end else if (access && bus.pwrite && inRange) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (int'(idx) == i) begin
                    entries[i] <= entryT'(bus.pwdata[ENTRY_BITS-1:0]);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/videoTiming.sv
`timescale 1ns/1ps
`default_nettype none

module videoTiming import ppuPkg::*; (
    input  wire logic          clk_50MHz,
    input  wire logic          rstn,
    output logic [POS_BITS-1:0] pixX,
    output logic [POS_BITS-1:0] pixY,
    output logic               hsync,
    output logic               vsync,
    output logic               inWindow,
    output logic               frameEnd
);

    logic [POS_BITS-1:0] nextX;
    logic [POS_BITS-1:0] nextY;
    logic                lineEnd;

    assign lineEnd = (pixX == POS_BITS'(H_TOTAL - 1));
    assign nextX   = lineEnd ? '0 : pixX + 1'b1;

    always_comb begin
        nextY = pixY;
        if (lineEnd) begin
            nextY = (pixY == POS_BITS'(V_TOTAL - 1)) ? '0 : pixY + 1'b1;
        end
    end

    // flags decoded from the next position so they line up with the counters
    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            pixX     <= '0;
            pixY     <= '0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            inWindow <= 1'b0;
            frameEnd <= 1'b0;
        end else begin
            pixX     <= nextX;
            pixY     <= nextY;
            hsync    <= (nextX >= POS_BITS'(H_SYNC_START)) && (nextX <= POS_BITS'(H_SYNC_END));
            vsync    <= (nextY >= POS_BITS'(V_SYNC_START)) && (nextY <= POS_BITS'(V_SYNC_END));
            inWindow <= (nextX >= POS_BITS'(WIN_X0)) && (nextX < POS_BITS'(WIN_X0 + WIN_W))
                     && (nextY >= POS_BITS'(WIN_Y0)) && (nextY < POS_BITS'(WIN_Y0 + WIN_H));
            frameEnd <= (nextX == POS_BITS'(WIN_X0 + WIN_W - 1))
                     && (nextY == POS_BITS'(WIN_Y0 + WIN_H - 1));   // last window pixel
        end
    end

endmodule

`default_nettype wire

// File: logic/spriteRender.sv
`timescale 1ns/1ps
`default_nettype none

module spriteRender import ppuPkg::*; (
    input  wire logic           clk_50MHz,
    input  wire logic           rstn,
    input  wire logic [POS_BITS-1:0] pixX,
    input  wire logic [POS_BITS-1:0] pixY,
    input  spriteEntryT         sprites [NUM_SPRITES],
    output rgbT                 spriteColor,
    output logic                spriteHit
);

    logic [POS_BITS-1:0] winX;
    logic [POS_BITS-1:0] winY;
    logic                hitNext;
    rgbT                 colorNext;

    assign winX = pixX - POS_BITS'(WIN_X0);
    assign winY = pixY - POS_BITS'(WIN_Y0);

    always_comb begin
        logic [POS_BITS-1:0] dx;
        logic [POS_BITS-1:0] dy;
        hitNext   = 1'b0;
        colorNext = '0;
        // walk down so the lowest index is assigned last
        for (int i = NUM_SPRITES - 1; i >= 0; i--) begin
            dx = winX - POS_BITS'(sprites[i].x);
            dy = winY - POS_BITS'(sprites[i].y);
            if (sprites[i].enable && dx < POS_BITS'(TILE_SIZE)
                    && dy < POS_BITS'(TILE_SIZE)) begin
                hitNext   = 1'b1;
                colorNext = sprites[i].color;
            end
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            spriteHit   <= 1'b0;
            spriteColor <= '0;
        end else begin
            spriteHit   <= hitNext;
            spriteColor <= colorNext;
        end
    end

endmodule

`default_nettype wire

// File: logic/backgroundRender.sv
`timescale 1ns/1ps
`default_nettype none

module backgroundRender import ppuPkg::*; (
    input  wire logic           clk_50MHz,
    input  wire logic           rstn,
    input  wire logic [POS_BITS-1:0] pixX,
    input  wire logic [POS_BITS-1:0] pixY,
    input  tileEntryT           tiles [NUM_TILES],
    output rgbT                 bgColor
);

    logic [POS_BITS-1:0] winX;
    logic [POS_BITS-1:0] winY;
    logic                inWin;
    int                  tileIdx;
    rgbT                 colorNext;

    assign winX  = pixX - POS_BITS'(WIN_X0);
    assign winY  = pixY - POS_BITS'(WIN_Y0);
    assign inWin = (winX < POS_BITS'(WIN_W)) && (winY < POS_BITS'(WIN_H));   // wraps below origin

    // row * cols + col, clamped outside the window
    assign tileIdx = inWin ? int'(winY >> TILE_SHIFT) * TILE_COLS + int'(winX >> TILE_SHIFT) : 0;

    always_comb begin
        colorNext = '0;
        for (int i = 0; i < NUM_TILES; i++) begin
            if (tileIdx == i) begin
                colorNext = tiles[i].color;
            end
        end
    end

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            bgColor <= '0;
        end else begin
            bgColor <= colorNext;
        end
    end

endmodule

`default_nettype wire

// File: logic/pixelMixer.sv
`timescale 1ns/1ps
`default_nettype none

module pixelMixer import ppuPkg::*; (
    input  wire logic clk_50MHz,
    input  wire logic rstn,
    input  rgbT       spriteColor,
    input  wire logic spriteHit,
    input  rgbT       bgColor,
    input  wire logic inWindow,
    input  wire logic hsyncIn,
    input  wire logic vsyncIn,
    input  wire logic frameEndIn,
    output rgbT       rgb,
    output logic      hsync,
    output logic      vsync,
    output logic      frameIntr
);

    logic inWindowD;
    logic hsyncD;
    logic vsyncD;
    logic frameEndD;
    logic useSprite;

    // key is taken from the winning sprite only
    assign useSprite = spriteHit && (spriteColor != TRANSPARENT_KEY0)
                    && (spriteColor != TRANSPARENT_KEY1);

    always_ff @(posedge clk_50MHz) begin
        if (!rstn) begin
            inWindowD <= 1'b0;
            hsyncD    <= 1'b0;
            vsyncD    <= 1'b0;
            frameEndD <= 1'b0;
            rgb       <= '0;
            hsync     <= 1'b0;
            vsync     <= 1'b0;
            frameIntr <= 1'b0;
        end else begin
            inWindowD <= inWindow;   // matches renderer latency
            hsyncD    <= hsyncIn;
            vsyncD    <= vsyncIn;
            frameEndD <= frameEndIn;
            rgb       <= !inWindowD ? rgbT'('0) : (useSprite ? spriteColor : bgColor);
            hsync     <= hsyncD;
            vsync     <= vsyncD;
            frameIntr <= frameEndD;
        end
    end

endmodule

`default_nettype wire

// File: logic/topPpu.sv
`timescale 1ns/1ps
`default_nettype none

module topPpu import ppuPkg::*; (
    input  wire logic                     clk_50MHz,
    input  wire logic                     rstn,

    input  wire logic                     sprPsel,
    input  wire logic                     sprPenable,
    input  wire logic                     sprPwrite,
    input  wire logic [APB_ADDR_BITS-1:0] sprPaddr,
    input  wire logic [APB_DATA_BITS-1:0] sprPwdata,
    output logic      [APB_DATA_BITS-1:0] sprPrdata,
    output logic                          sprPready,
    output logic                          sprPslverr,

    input  wire logic                     ntPsel,
    input  wire logic                     ntPenable,
    input  wire logic                     ntPwrite,
    input  wire logic [APB_ADDR_BITS-1:0] ntPaddr,
    input  wire logic [APB_DATA_BITS-1:0] ntPwdata,
    output logic      [APB_DATA_BITS-1:0] ntPrdata,
    output logic                          ntPready,
    output logic                          ntPslverr,

    output logic                          hsync,
    output logic                          vsync,
    output rgbT                           rgb,
    output logic                          frameIntr
);

    apbIf sprBus ();
    apbIf ntBus ();

    assign sprBus.psel    = sprPsel;
    assign sprBus.penable = sprPenable;
    assign sprBus.pwrite  = sprPwrite;
    assign sprBus.paddr   = sprPaddr;
    assign sprBus.pwdata  = sprPwdata;
    assign sprPrdata      = sprBus.prdata;
    assign sprPready      = sprBus.pready;
    assign sprPslverr     = sprBus.pslverr;

    assign ntBus.psel    = ntPsel;
    assign ntBus.penable = ntPenable;
    assign ntBus.pwrite  = ntPwrite;
    assign ntBus.paddr   = ntPaddr;
    assign ntBus.pwdata  = ntPwdata;
    assign ntPrdata      = ntBus.prdata;
    assign ntPready      = ntBus.pready;
    assign ntPslverr     = ntBus.pslverr;

    spriteEntryT         sprites [NUM_SPRITES];
    tileEntryT           tiles [NUM_TILES];
    logic [POS_BITS-1:0] pixX;
    logic [POS_BITS-1:0] pixY;
    logic                rawHsync;
    logic                rawVsync;
    logic                inWindow;
    logic                frameEnd;
    rgbT                 spriteColor;
    logic                spriteHit;
    rgbT                 bgColor;

    apbTableRam #(.entryT(spriteEntryT), .DEPTH(NUM_SPRITES)) spriteTable (
        .clk_50MHz(clk_50MHz), .rstn(rstn), .bus(sprBus), .entries(sprites)
    );

    apbTableRam #(.entryT(tileEntryT), .DEPTH(NUM_TILES)) nameTable (
        .clk_50MHz(clk_50MHz), .rstn(rstn), .bus(ntBus), .entries(tiles)
    );

    videoTiming timing (
        .clk_50MHz(clk_50MHz), .rstn(rstn), .pixX(pixX), .pixY(pixY),
        .hsync(rawHsync), .vsync(rawVsync), .inWindow(inWindow), .frameEnd(frameEnd)
    );

    spriteRender sprRender (
        .clk_50MHz(clk_50MHz), .rstn(rstn), .pixX(pixX), .pixY(pixY),
        .sprites(sprites), .spriteColor(spriteColor), .spriteHit(spriteHit)
    );

    backgroundRender bgRender (
        .clk_50MHz(clk_50MHz), .rstn(rstn), .pixX(pixX), .pixY(pixY),
        .tiles(tiles), .bgColor(bgColor)
    );

    pixelMixer mixer (
        .clk_50MHz(clk_50MHz), .rstn(rstn),
        .spriteColor(spriteColor), .spriteHit(spriteHit), .bgColor(bgColor),
        .inWindow(inWindow), .hsyncIn(rawHsync), .vsyncIn(rawVsync),
        .frameEndIn(frameEnd),
        .rgb(rgb), .hsync(hsync), .vsync(vsync), .frameIntr(frameIntr)
    );

endmodule

`default_nettype wire

// File: tests/topPpu_props.sv
`timescale 1ns/1ps
`default_nettype none

module topPpu_props import ppuPkg::*; (
    input wire logic clk_50MHz,
    input wire logic rstn,
    input wire logic sprPsel,
    input wire logic sprPenable,
    input wire logic sprPready,
    input wire logic sprPslverr,
    input wire logic ntPsel,
    input wire logic ntPenable,
    input wire logic ntPready,
    input wire logic ntPslverr,
    input wire logic hsync,
    input wire logic vsync,
    input wire logic frameIntr,
    input wire rgbT  rgb
);

    // slaves answer only in the access phase
    sprResponse: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        (sprPready || sprPslverr) |-> (sprPsel && sprPenable))
        else $error("sprite table answered outside an access cycle");

    ntResponse: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        (ntPready || ntPslverr) |-> (ntPsel && ntPenable))
        else $error("name table answered outside an access cycle");

    framePulse: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        frameIntr |=> !frameIntr)
        else $error("frame interrupt held for more than one cycle");

    blankDuringSync: assert property (@(posedge clk_50MHz) disable iff (!rstn)
        (hsync || vsync) |-> (rgb == '0))
        else $error("colour driven during a sync pulse");

endmodule

bind topPpu topPpu_props props (
    .clk_50MHz(clk_50MHz), .rstn(rstn),
    .sprPsel(sprPsel), .sprPenable(sprPenable), .sprPready(sprPready), .sprPslverr(sprPslverr),
    .ntPsel(ntPsel), .ntPenable(ntPenable), .ntPready(ntPready), .ntPslverr(ntPslverr),
    .hsync(hsync), .vsync(vsync), .frameIntr(frameIntr), .rgb(rgb)
);

`default_nettype wire

// File: tests/tb_topPpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_topPpu import ppuPkg::*; ();

    localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL;
    localparam int TIMEOUT_CYCLES = 6 * FRAME_CYCLES + 1600;   // alignment frame, five tests, apb
    localparam int LAST_X         = WIN_X0 + WIN_W - 1;
    localparam int LAST_Y         = WIN_Y0 + WIN_H - 1;

    logic                     clk_50MHz;
    logic                     rstn;
    logic                     sprPsel;
    logic                     sprPenable;
    logic                     sprPwrite;
    logic [APB_ADDR_BITS-1:0] sprPaddr;
    logic [APB_DATA_BITS-1:0] sprPwdata;
    logic [APB_DATA_BITS-1:0] sprPrdata;
    logic                     sprPready;
    logic                     sprPslverr;
    logic                     ntPsel;
    logic                     ntPenable;
    logic                     ntPwrite;
    logic [APB_ADDR_BITS-1:0] ntPaddr;
    logic [APB_DATA_BITS-1:0] ntPwdata;
    logic [APB_DATA_BITS-1:0] ntPrdata;
    logic                     ntPready;
    logic                     ntPslverr;
    logic                     hsync;
    logic                     vsync;
    rgbT                      rgb;
    logic                     frameIntr;

    logic [31:0] lfsr;
    logic [24:0] sprShadow [NUM_SPRITES];
    logic [11:0] tileShadow [NUM_TILES];
    int          errorCount;
    int          testStart;
    int          testsPassed;
    int          testsFailed;
    int          cycles;
    int          posX;
    int          posY;
    int          sinceFrame;
    logic        aligned;
    logic        checking;

    topPpu DUT (.*);

    always #10 clk_50MHz = ~clk_50MHz;

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
    endfunction

    // one step per bit taken
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [11:0] randColor();
        logic [11:0] c;
        do begin
            c = 12'(randBits(12));
        end while (c == 12'h000 || c == 12'h209);   // skip the keys
        return c;
    endfunction

    function automatic logic [11:0] expectedPixel(input int x, input int y,
            input logic [24:0] spr [NUM_SPRITES], input logic [11:0] tiles [NUM_TILES]);
        int          wx;
        int          wy;
        int          sx;
        int          sy;
        logic [11:0] bg;
        if (x < WIN_X0 || x > LAST_X || y < WIN_Y0 || y > LAST_Y) begin
            return 12'h000;
        end
        wx = x - WIN_X0;
        wy = y - WIN_Y0;
        bg = tiles[(wy / TILE_SIZE) * TILE_COLS + wx / TILE_SIZE];
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sx = int'(spr[i][17:12]);
            sy = int'(spr[i][23:18]);
            if (spr[i][24] && wx >= sx && wx < sx + TILE_SIZE
                    && wy >= sy && wy < sy + TILE_SIZE) begin
                // winner decides, even if it is a key
                if (spr[i][11:0] == 12'h000 || spr[i][11:0] == 12'h209) begin
                    return bg;
                end
                return spr[i][11:0];
            end
        end
        return bg;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("mismatch at time %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic driveBus(input bit toNt, input logic sel, input logic en, input logic wr,
                            input int index, input logic [31:0] data);
        if (toNt) begin
            ntPsel    = sel;
            ntPenable = en;
            ntPwrite  = wr;
            ntPaddr   = 8'(index * 4);
            ntPwdata  = data;
        end else begin
            sprPsel    = sel;
            sprPenable = en;
            sprPwrite  = wr;
            sprPaddr   = 8'(index * 4);
            sprPwdata  = data;
        end
    endtask

    task automatic apbWrite(input bit toNt, input int index, input logic [31:0] data);
        int depth;
        depth = toNt ? NUM_TILES : NUM_SPRITES;
        @(negedge clk_50MHz);
        driveBus(toNt, 1'b1, 1'b0, 1'b1, index, data);   // setup
        @(negedge clk_50MHz);
        driveBus(toNt, 1'b1, 1'b1, 1'b1, index, data);   // access
        @(posedge clk_50MHz);
        checkValue(32'(toNt ? ntPready : sprPready), 32'h1, "pready on write");
        checkValue(32'(toNt ? ntPslverr : sprPslverr), 32'(index >= depth), "pslverr on write");
        if (index < depth && toNt) begin
            tileShadow[index] = data[11:0];
        end else if (index < depth) begin
            sprShadow[index] = data[24:0];
        end
        @(negedge clk_50MHz);
        driveBus(toNt, 1'b0, 1'b0, 1'b0, 0, 32'h0);
    endtask

    task automatic apbRead(input bit toNt, input int index, input logic [31:0] expected);
        int depth;
        depth = toNt ? NUM_TILES : NUM_SPRITES;
        @(negedge clk_50MHz);
        driveBus(toNt, 1'b1, 1'b0, 1'b0, index, 32'h0);
        @(negedge clk_50MHz);
        driveBus(toNt, 1'b1, 1'b1, 1'b0, index, 32'h0);
        @(posedge clk_50MHz);
        checkValue(32'(toNt ? ntPready : sprPready), 32'h1, "pready on read");
        checkValue(32'(toNt ? ntPslverr : sprPslverr), 32'(index >= depth), "pslverr on read");
        checkValue(toNt ? ntPrdata : sprPrdata, expected,
                   $sformatf("read data of entry %0d", index));
        @(negedge clk_50MHz);
        driveBus(toNt, 1'b0, 1'b0, 1'b0, 0, 32'h0);
    endtask

    task automatic waitFrame();
        do begin
            @(negedge clk_50MHz);
        end while (!frameIntr);
        @(posedge clk_50MHz);   // compare process is done with this pixel
    endtask

    task automatic endTest(input int num, input string name);
        int errs;
        errs = errorCount - testStart;
        if (errs == 0) begin
            testsPassed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errs);
        end
        testStart = errorCount;
    endtask

    // raster position tracked from frameIntr, which marks the last window pixel
    always @(negedge clk_50MHz) begin
        if (rstn) begin
            sinceFrame++;
            if (frameIntr) begin
                if (aligned) begin
                    checkValue(32'(sinceFrame), 32'(FRAME_CYCLES), "frame interrupt spacing");
                end
                aligned    = 1'b1;
                posX       = LAST_X;
                posY       = LAST_Y;
                sinceFrame = 0;
            end else if (aligned) begin
                posX = (posX == H_TOTAL - 1) ? 0 : posX + 1;
                if (posX == 0) begin
                    posY = (posY == V_TOTAL - 1) ? 0 : posY + 1;
                end
            end
            if (checking) begin
                checkValue(32'(rgb), 32'(expectedPixel(posX, posY, sprShadow, tileShadow)),
                           $sformatf("rgb at pixel (%0d,%0d)", posX, posY));
                checkValue(32'(hsync), 32'(posX >= H_SYNC_START && posX <= H_SYNC_END),
                           $sformatf("hsync at pixel (%0d,%0d)", posX, posY));
                checkValue(32'(vsync), 32'(posY >= V_SYNC_START && posY <= V_SYNC_END),
                           $sformatf("vsync at pixel (%0d,%0d)", posX, posY));
            end else if (!aligned) begin
                checkValue(32'(rgb), 32'h0, "rgb before the first frame");
            end
        end
    end

    always @(posedge clk_50MHz) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int sx;
        int sy;
        clk_50MHz = 1'b0;
        rstn      = 1'b0;
        driveBus(1'b0, 1'b0, 1'b0, 1'b0, 0, 32'h0);
        driveBus(1'b1, 1'b0, 1'b0, 1'b0, 0, 32'h0);
        lfsr        = 32'hd5f3;
        errorCount  = 0;
        testStart   = 0;
        testsPassed = 0;
        testsFailed = 0;
        cycles      = 0;
        posX        = 0;
        posY        = 0;
        sinceFrame  = 0;
        aligned     = 1'b0;
        checking    = 1'b0;
        sx          = 0;
        sy          = 0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            sprShadow[i] = '0;
        end
        for (int i = 0; i < NUM_TILES; i++) begin
            tileShadow[i] = '0;
        end
        repeat (4) @(negedge clk_50MHz);
        rstn = 1'b1;

        waitFrame();
        checking = 1'b1;
        waitFrame();
        endTest(1, "empty tables");

        for (int i = 0; i < NUM_TILES; i++) begin
            apbWrite(1'b1, i, randBits(12));
        end
        waitFrame();
        endTest(2, "background tiles");

        // sprite 1 sits on sprite 0, sprite 6 stays disabled
        for (int i = 0; i < NUM_SPRITES; i++) begin
            if (i == 1) begin
                sx = sx + 3;
                sy = sy + 2;
            end else begin
                sx = int'(randBits(6) % 57);
                sy = int'(randBits(6) % 41);
            end
            apbWrite(1'b0, i, {7'b0, i != 6, 6'(sy), 6'(sx), randColor()});
        end
        waitFrame();
        endTest(3, "sprite priority");

        apbWrite(1'b0, 2, {7'b0, 1'b1, sprShadow[4][23:12], 12'h000});
        apbWrite(1'b0, 3, {7'b0, 1'b1, sprShadow[5][23:12], 12'h209});
        waitFrame();
        endTest(4, "transparent keys");

        for (int i = 0; i < NUM_SPRITES; i++) begin
            apbRead(1'b0, i, {7'b0, sprShadow[i]});
        end
        for (int i = 0; i < NUM_TILES; i++) begin
            apbRead(1'b1, i, {20'b0, tileShadow[i]});
        end
        apbWrite(1'b0, NUM_SPRITES, 32'hffff_ffff);
        apbWrite(1'b1, NUM_TILES, 32'hffff_ffff);
        apbRead(1'b0, NUM_SPRITES, 32'h0);
        apbRead(1'b1, NUM_TILES, 32'h0);
        waitFrame();
        endTest(5, "readback and bus errors");

        checking = 1'b0;
        $display("summary: %0d tests passed, %0d failed, %0d mismatches",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
logic/ppuPkg.sv
logic/apbIf.sv
logic/apbTableRam.sv
logic/videoTiming.sv
logic/spriteRender.sv
logic/backgroundRender.sv
logic/pixelMixer.sv
logic/topPpu.sv
tests/topPpu_props.sv
tests/tb_topPpu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= tb_topPpu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
